/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;      // Data and address width
	localparam int reg_addr_w = 5; // Register address width

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		op_other  = 7'b0000000, // Anything unsupported, runs as a no-op
		op_load   = 7'b0000011,
		op_imm    = 7'b0010011,
		op_store  = 7'b0100011,
		op_reg    = 7'b0110011,
		op_lui    = 7'b0110111,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_sll    = 4'd7,
		alu_srl    = 4'd8,
		alu_sra    = 4'd9,
		alu_pass_b = 4'd10 // Used by LUI
	} alu_op_e;

endpackage

`default_nettype wire

/* hdl/rv_alu.sv */
`default_nettype none

module rv_alu (
	input wire rv_pkg::alu_op_e op,
	input wire [rv_pkg::xlen-1:0] a,
	input wire [rv_pkg::xlen-1:0] b,
	output logic [rv_pkg::xlen-1:0] y,
	output logic zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rv_pkg::alu_add: y = a + b;
			rv_pkg::alu_sub: y = a - b;
			rv_pkg::alu_and: y = a & b;
			rv_pkg::alu_or: y = a | b;
			rv_pkg::alu_xor: y = a ^ b;
			rv_pkg::alu_slt: y = {{(rv_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
			rv_pkg::alu_sltu: y = {{(rv_pkg::xlen-1){1'b0}}, (a < b)};
			rv_pkg::alu_sll: y = a << shamt;
			rv_pkg::alu_srl: y = a >> shamt;
			rv_pkg::alu_sra: y = $unsigned($signed(a) >>> shamt); // Sign bit fills in
			rv_pkg::alu_pass_b: y = b;
			default: y = '0;
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`default_nettype none

module rv_regfile (
	input wire clk,
	input wire rst,
	input wire we,
	input wire [rv_pkg::reg_addr_w-1:0] ra,
	input wire [rv_pkg::reg_addr_w-1:0] rb,
	input wire [rv_pkg::reg_addr_w-1:0] rw,
	input wire [rv_pkg::xlen-1:0] wd,
	output logic [rv_pkg::xlen-1:0] rd_a,
	output logic [rv_pkg::xlen-1:0] rd_b
);

	logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**rv_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rw != '0)) begin // x0 is never written
			regs[rw] <= wd;
		end
	end

	assign rd_a = (ra == '0) ? '0 : regs[ra];
	assign rd_b = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

/* hdl/rv_pc.sv */
`default_nettype none

module rv_pc #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
	input wire clk,
	input wire rst,
	input wire step,
	input wire jump,
	input wire [rv_pkg::xlen-1:0] target,
	output logic [rv_pkg::xlen-1:0] pc
);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (jump) begin // Jump has priority over step
			pc <= target;
		end else if (step) begin
			pc <= pc + rv_pkg::xlen'(4);
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`default_nettype none

module rv_decode (
	input wire clk,
	input wire rst,
	input wire load,
	input wire [rv_pkg::xlen-1:0] instr_in,
	output logic [rv_pkg::reg_addr_w-1:0] ra,
	output logic [rv_pkg::reg_addr_w-1:0] rb,
	output logic [rv_pkg::reg_addr_w-1:0] rw,
	output logic [rv_pkg::xlen-1:0] imm,
	output rv_pkg::opcode_e opcode,
	output rv_pkg::alu_op_e alu_op,
	output logic alu_src_imm,
	output logic branch_ne
);

	logic [rv_pkg::xlen-1:0] ir;
	logic [2:0] funct3;
	logic [rv_pkg::xlen-1:0] imm_i;
	logic [rv_pkg::xlen-1:0] imm_s;
	logic [rv_pkg::xlen-1:0] imm_b;
	logic [rv_pkg::xlen-1:0] imm_j;
	logic [rv_pkg::xlen-1:0] imm_u;
	rv_pkg::alu_op_e func_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			ir <= '0; // Decodes as op_other
		end else if (load) begin
			ir <= instr_in;
		end
	end

	assign ra = ir[19:15];
	assign rb = ir[24:20];
	assign rw = ir[11:7];
	assign funct3 = ir[14:12];
	assign branch_ne = funct3[0];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};

	// Only BEQ/BNE and word LW/SW are supported in their opcode groups
	always_comb begin
		case (ir[6:0])
			rv_pkg::op_lui, rv_pkg::op_jal, rv_pkg::op_imm, rv_pkg::op_reg:
				opcode = rv_pkg::opcode_e'(ir[6:0]);
			rv_pkg::op_branch:
				opcode = (funct3[2:1] == 2'b00) ? rv_pkg::op_branch : rv_pkg::op_other;
			rv_pkg::op_load, rv_pkg::op_store:
				opcode = (funct3 == 3'b010) ? rv_pkg::opcode_e'(ir[6:0]) : rv_pkg::op_other;
			default: opcode = rv_pkg::op_other;
		endcase
	end

	// ALU op from funct3, with bit 30 for SUB and SRA
	always_comb begin
		case (funct3)
			3'b000: func_op = (opcode == rv_pkg::op_reg && ir[30]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: func_op = rv_pkg::alu_sll;
			3'b010: func_op = rv_pkg::alu_slt;
			3'b011: func_op = rv_pkg::alu_sltu;
			3'b100: func_op = rv_pkg::alu_xor;
			3'b101: func_op = ir[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: func_op = rv_pkg::alu_or;
			default: func_op = rv_pkg::alu_and;
		endcase
	end

	always_comb begin
		imm = imm_i;
		alu_op = rv_pkg::alu_add;
		alu_src_imm = 1'b0;
		case (opcode)
			rv_pkg::op_lui: begin
				imm = imm_u;
				alu_op = rv_pkg::alu_pass_b;
				alu_src_imm = 1'b1;
			end
			rv_pkg::op_jal: imm = imm_j; // ALU adds PC and 4 for the link
			rv_pkg::op_branch: begin
				imm = imm_b;
				alu_op = rv_pkg::alu_sub; // Compare through the zero flag
			end
			rv_pkg::op_load: alu_src_imm = 1'b1;
			rv_pkg::op_store: begin
				imm = imm_s;
				alu_src_imm = 1'b1;
			end
			rv_pkg::op_imm: begin
				alu_op = func_op;
				alu_src_imm = 1'b1;
			end
			rv_pkg::op_reg: alu_op = func_op;
			default: alu_op = rv_pkg::alu_add;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/rv_ctrl_fsm.sv */
`default_nettype none

module rv_ctrl_fsm (
	input wire clk,
	input wire rst,
	input wire rv_pkg::opcode_e opcode,
	input wire branch_ne,
	input wire alu_zero,
	input wire ack,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic ir_load,
	output logic op_load,
	output logic pc_step,
	output logic pc_jump,
	output logic rf_write,
	output logic wb_sel_mem,
	output logic mem_phase
);

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem,
		st_writeback
	} state_e;

	state_e state;
	logic bus_req; // Drives both cyc and stb
	logic bus_we;
	logic mem_op;
	logic writes_reg;

	assign mem_op = (opcode == rv_pkg::op_load) || (opcode == rv_pkg::op_store);
	assign writes_reg = (opcode == rv_pkg::op_lui) || (opcode == rv_pkg::op_jal) ||
		(opcode == rv_pkg::op_imm) || (opcode == rv_pkg::op_reg);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_fetch;
			bus_req <= 1'b0;
			bus_we <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!bus_req) begin // Only after reset or a store
						bus_req <= 1'b1;
						bus_we <= 1'b0;
					end else if (ack) begin
						bus_req <= 1'b0;
						state <= st_decode;
					end
				end
				st_decode: state <= st_execute;
				st_execute: begin
					if (mem_op) begin
						state <= st_mem;
						bus_req <= 1'b1; // Address is the ALU sum from here on
						bus_we <= (opcode == rv_pkg::op_store);
					end else if (writes_reg) begin
						state <= st_writeback;
					end else begin
						state <= st_fetch; // Branch or no-op, fetch next right away
						bus_req <= 1'b1;
						bus_we <= 1'b0;
					end
				end
				st_mem: begin
					if (ack) begin
						bus_req <= 1'b0;
						bus_we <= 1'b0;
						state <= (opcode == rv_pkg::op_load) ? st_writeback : st_fetch;
					end
				end
				st_writeback: begin
					state <= st_fetch;
					bus_req <= 1'b1;
					bus_we <= 1'b0;
				end
				default: state <= st_fetch;
			endcase
		end
	end

	assign cyc = bus_req;
	assign stb = bus_req;
	assign we = bus_we;

	assign ir_load = (state == st_fetch) && bus_req && ack; // Instruction word on dat_r
	assign op_load = (state == st_decode);
	assign mem_phase = (state == st_mem);

	// BEQ taken on zero, BNE taken on non-zero
	assign pc_jump = (state == st_execute) && ((opcode == rv_pkg::op_jal) ||
		((opcode == rv_pkg::op_branch) && (alu_zero != branch_ne)));
	assign pc_step = (state == st_execute) && !pc_jump;

	assign rf_write = (state == st_writeback);
	assign wb_sel_mem = (opcode == rv_pkg::op_load);

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
	input wire clk,
	input wire rst,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic [rv_pkg::xlen-1:0] adr,
	output logic [rv_pkg::xlen-1:0] dat_w,
	input wire [rv_pkg::xlen-1:0] dat_r,
	input wire ack
);

	// FSM strobes
	logic ir_load;
	logic op_load;
	logic pc_step;
	logic pc_jump;
	logic rf_write;
	logic wb_sel_mem;
	logic mem_phase;

	// Decode outputs
	logic [rv_pkg::reg_addr_w-1:0] ra;
	logic [rv_pkg::reg_addr_w-1:0] rb;
	logic [rv_pkg::reg_addr_w-1:0] rw;
	logic [rv_pkg::xlen-1:0] imm;
	rv_pkg::opcode_e opcode;
	rv_pkg::alu_op_e alu_op;
	logic alu_src_imm;
	logic branch_ne;

	// Datapath
	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] branch_target;
	logic [rv_pkg::xlen-1:0] rd_a;
	logic [rv_pkg::xlen-1:0] rd_b;
	logic [rv_pkg::xlen-1:0] op_a;
	logic [rv_pkg::xlen-1:0] op_b;
	logic [rv_pkg::xlen-1:0] alu_b;
	logic [rv_pkg::xlen-1:0] alu_y;
	logic alu_zero;
	logic [rv_pkg::xlen-1:0] mem_data;
	logic [rv_pkg::xlen-1:0] wb_data;

	rv_ctrl_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.branch_ne(branch_ne),
		.alu_zero(alu_zero),
		.ack(ack),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.ir_load(ir_load),
		.op_load(op_load),
		.pc_step(pc_step),
		.pc_jump(pc_jump),
		.rf_write(rf_write),
		.wb_sel_mem(wb_sel_mem),
		.mem_phase(mem_phase)
	);

	rv_pc #(
		.reset_pc(reset_pc)
	) u_pc (
		.clk(clk),
		.rst(rst),
		.step(pc_step),
		.jump(pc_jump),
		.target(branch_target),
		.pc(pc)
	);

	rv_decode u_decode (
		.clk(clk),
		.rst(rst),
		.load(ir_load),
		.instr_in(dat_r),
		.ra(ra),
		.rb(rb),
		.rw(rw),
		.imm(imm),
		.opcode(opcode),
		.alu_op(alu_op),
		.alu_src_imm(alu_src_imm),
		.branch_ne(branch_ne)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.we(rf_write),
		.ra(ra),
		.rb(rb),
		.rw(rw),
		.wd(wb_data),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	rv_alu u_alu (
		.op(alu_op),
		.a(op_a),
		.b(alu_b),
		.y(alu_y),
		.zero(alu_zero)
	);

	// JAL takes old PC and 4 so the ALU yields the link value
	always_ff @(posedge clk) begin
		if (op_load) begin
			op_a <= (opcode == rv_pkg::op_jal) ? pc : rd_a;
			op_b <= (opcode == rv_pkg::op_jal) ? rv_pkg::xlen'(4) : rd_b;
		end
	end

	// Load data held for the write-back cycle
	always_ff @(posedge clk) begin
		if (mem_phase && ack) begin
			mem_data <= dat_r;
		end
	end

	assign branch_target = pc + imm; // PC still holds the current instruction
	assign alu_b = alu_src_imm ? imm : op_b;
	assign wb_data = wb_sel_mem ? mem_data : alu_y;
	assign adr = mem_phase ? alu_y : pc;
	assign dat_w = rd_b;

endmodule

`default_nettype wire

/* test/rv_core_assert.sv */
`default_nettype none

module rv_core_wb_assert (
	input wire clk,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [rv_pkg::xlen-1:0] adr,
	input wire [rv_pkg::xlen-1:0] dat_w,
	input wire ack
);

	stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
		else $error("stb high while cyc is low");

	// Request held until the slave acknowledges
	req_stable: assert property (@(posedge clk) disable iff (rst)
		(stb && !ack) |=> (stb && $stable(adr) && $stable(we) && $stable(dat_w)))
		else $error("bus request changed before ack");

	adr_aligned: assert property (@(posedge clk) disable iff (rst) stb |-> (adr[1:0] == 2'b00))
		else $error("bus address not word aligned");

	reset_clears_cyc: assert property (@(posedge clk) rst |=> !cyc)
		else $error("cyc high in the cycle after reset");

endmodule

bind rv_core rv_core_wb_assert u_wb_assert (
	.clk(clk),
	.rst(rst),
	.cyc(cyc),
	.stb(stb),
	.we(we),
	.adr(adr),
	.dat_w(dat_w),
	.ack(ack)
);

`default_nettype wire

/* test/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

	localparam int drive_dly = 2;       // Input drive delay after the clock edge
	localparam int req_timeout = 100;   // Cycles allowed between bus requests
	localparam int run_timeout = 20000; // Cycles allowed for the whole program
	localparam int max_stores = 64;

	logic clk = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [rv_pkg::xlen-1:0] adr;
	logic [rv_pkg::xlen-1:0] dat_w;
	logic [rv_pkg::xlen-1:0] dat_r;
	logic ack;

	logic [31:0] mem [1024]; // 4 KB memory, word indexed
	logic [8*24-1:0] exp_name [max_stores];
	logic [31:0] exp_adr [max_stores];
	logic [31:0] exp_dat [max_stores];
	int n_stores;
	int n_seen;
	int total_cycles;
	logic [31:0] lfsr = 32'h5f2c_4f77;

	rv_core #(
		.reset_pc(32'h0000_0000)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #20 clk = ~clk;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [8*24-1:0] name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("CHECK FAILED %0s %0s expected %h actual %h",
				name, field, expected, actual));
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int draw_bits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | lfsr[0];
		end
		return val;
	endfunction

	task automatic load_tests();
		int fd;
		int rc;
		logic reading;
		logic [8*8-1:0] tag;
		logic [8*200-1:0] line;
		logic [31:0] a;
		logic [31:0] d;
		logic [8*24-1:0] name;
		fd = $fopen("test/rv_core_tests.txt", "r");
		if (fd == 0) begin
			stop_run("could not open test/rv_core_tests.txt");
		end
		n_stores = 0;
		reading = 1'b1;
		while (reading) begin
			if ($fscanf(fd, "%s", tag) != 1) begin
				reading = 1'b0;
			end else if (tag == "#") begin
				rc = $fgets(line, fd); // Skip the comment text
			end else if (tag == "P") begin
				rc = $fscanf(fd, "%h %h", a, d);
				if (rc != 2) begin
					stop_run("malformed program line in the tests file");
				end
				mem[a[11:2]] = d;
			end else if (tag == "W") begin
				rc = $fscanf(fd, "%s %h %h", name, a, d);
				if (rc != 3) begin
					stop_run("malformed store line in the tests file");
				end
				if (n_stores >= max_stores) begin
					stop_run("too many expected stores in the tests file");
				end
				exp_name[n_stores] = name;
				exp_adr[n_stores] = a;
				exp_dat[n_stores] = d;
				n_stores++;
			end else begin
				stop_run("unknown line tag in the tests file");
			end
		end
		$fclose(fd);
	endtask

	task automatic wait_request();
		int waited;
		waited = 0;
		@(posedge clk);
		while (!stb) begin
			waited++;
			total_cycles++;
			if (waited >= req_timeout) begin
				stop_run("the core issued no bus request for 100 cycles");
			end
			if (total_cycles >= run_timeout) begin
				stop_run("not all expected stores were seen within 20000 cycles");
			end
			@(posedge clk);
		end
	endtask

	task automatic check_store(input logic [31:0] a, input logic [31:0] d);
		if (n_seen >= n_stores) begin
			stop_run($sformatf("unexpected extra store of %h to address %h", d, a));
		end
		check_value(exp_name[n_seen], "address", exp_adr[n_seen], a);
		check_value(exp_name[n_seen], "data", exp_dat[n_seen], d);
		n_seen++;
	endtask

	// Request values are stable until ack, so they are taken at detection
	task automatic serve_request();
		logic [31:0] req_adr;
		logic req_we;
		logic [31:0] req_dat;
		int delay;
		req_adr = adr;
		req_we = we;
		req_dat = dat_w;
		if (req_adr >= 32'h0000_1000) begin
			stop_run($sformatf("bus address %h is outside the 4 KB memory", req_adr));
		end
		if (req_we) begin
			check_store(req_adr, req_dat);
			mem[req_adr[11:2]] = req_dat;
		end
		delay = draw_bits(2); // 0 to 3 wait states
		repeat (delay) @(posedge clk);
		#drive_dly;
		dat_r = req_we ? 32'h0 : mem[req_adr[11:2]];
		ack = 1'b1;
		@(posedge clk);
		#drive_dly;
		ack = 1'b0;
		dat_r = '0;
		total_cycles += delay + 1;
	endtask

	initial begin
		rst = 1'b1;
		ack = 1'b0;
		dat_r = '0;
		n_seen = 0;
		total_cycles = 0;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'h0;
		end
		load_tests();
		repeat (5) @(posedge clk);
		#drive_dly;
		rst = 1'b0;
		while (n_seen < n_stores) begin
			wait_request();
			serve_request();
		end
		// Core should now spin on its final JAL with no more stores
		repeat (8) begin
			wait_request();
			serve_request();
		end
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/rv_core_tests.txt */
# P byte_address instruction_word
# W test_name store_address store_data, in program order
P 000 FEC00093
P 004 00700113
P 008 40000513
P 00C 002081B3
P 010 00352023
P 014 402081B3
P 018 00352223
P 01C 0020F1B3
P 020 00352423
P 024 0020E1B3
P 028 00352623
P 02C 0020C1B3
P 030 00352823
P 034 0020A1B3
P 038 00352A23
P 03C 0020B1B3
P 040 00352C23
P 044 002091B3
P 048 00352E23
P 04C 0020D1B3
P 050 02352023
P 054 4020D1B3
P 058 02352223
P 05C 06408193
P 060 02352423
P 064 7F00F193
P 068 02352623
P 06C 0030E193
P 070 02352823
P 074 0F00C193
P 078 02352A23
P 07C FFB0A193
P 080 02352C23
P 084 00409193
P 088 02352E23
P 08C 01C0D193
P 090 04352023
P 094 4030D193
P 098 04352223
P 09C 00510013
P 0A0 04052423
P 0A4 00052203
P 0A8 01020213
P 0AC 04452623
P 0B0 02C52283
P 0B4 FE028293
P 0B8 04552823
P 0BC 11100313
P 0C0 22200393
P 0C4 00208463
P 0C8 04652A23
P 0CC 00209463
P 0D0 04752C23
P 0D4 00210463
P 0D8 04752E23
P 0DC 00211463
P 0E0 06752023
P 0E4 0080046F
P 0E8 06752223
P 0EC 06852423
P 0F0 123454B7
P 0F4 06952623
P 0F8 00001117
P 0FC 06252823
P 100 0000006F
# Expected stores
W add 400 FFFFFFF3
W sub 404 FFFFFFE5
W and 408 00000004
W or 40C FFFFFFEF
W xor 410 FFFFFFEB
W slt 414 00000001
W sltu 418 00000000
W sll 41C FFFFF600
W srl 420 01FFFFFF
W sra 424 FFFFFFFF
W addi 428 00000050
W andi 42C 000007E0
W ori 430 FFFFFFEF
W xori 434 FFFFFF1C
W slti 438 00000001
W slli 43C FFFFFEC0
W srli 440 0000000F
W srai 444 FFFFFFFD
W x0_zero 448 00000000
W load_add 44C 00000003
W load_addi_neg 450 000007C0
W beq_not_taken 454 00000111
W bne_not_taken 460 00000222
W jal_link 468 000000E8
W lui 46C 12345000
W unknown_op 470 00000007

/* compile.f */
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_pc.sv
hdl/rv_decode.sv
hdl/rv_ctrl_fsm.sv
hdl/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_alu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_pc.sv
  - hdl/rv_decode.sv
  - hdl/rv_ctrl_fsm.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - test/rv_core_assert.sv
      - test/rv_core_tb.sv
